//--- project.f
+incdir+hw
hw/tetris_pkg.sv
hw/score_bus_if.sv
hw/clear_decode.sv
hw/bcd_score_adder.sv
hw/level_tracker.sv
hw/gravity_timer.sv
hw/tetris_score_top.sv
verification/tetris_score_asserts.sv
verification/tb_tetris_score.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the run by its log

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_tetris_score -f project.f \
  -Mdir obj_dir -o sim_tetris_score ||
  { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tetris_score > sim.log 2>&1
cat sim.log

grep -q "Test completed successfully" sim.log &&
  { echo "Simulation PASSED"; exit 0; } ||
  { echo "Simulation FAILED"; exit 1; }

//--- verification/tb_tetris_score.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_consts.svh"

module tb_tetris_score;

  logic        clk;
  logic        rst;
  logic        clear_strobe;
  logic        new_game;
  logic        tick_game;
  logic        piece_active;
  logic [2:0]  lines_cleared;
  logic [31:0] score;
  logic [3:0]  level;
  logic [3:0]  streak;
  logic        drop_request;

  integer seed;
  int     checks;
  int     errors;
  int     timeouts;

  // Reference model of the game progression
  int model_lines;
  int model_streak;
  int model_level;
  int model_score;

  tetris_score_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .clear_strobe  (clear_strobe),
    .new_game      (new_game),
    .tick_game     (tick_game),
    .piece_active  (piece_active),
    .lines_cleared (lines_cleared),
    .score         (score),
    .level         (level),
    .streak        (streak),
    .drop_request  (drop_request)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ======================================================================
  // Model helpers
  // ======================================================================
  function automatic int base_points(input int lines);
    case (lines)
      1:       return `SCORE_SINGLE;
      2:       return `SCORE_DOUBLE;
      3:       return `SCORE_TRIPLE;
      4:       return `SCORE_TETRIS;
      default: return 0;
    endcase
  endfunction

  function automatic int speed_for_level(input int lvl);
    int table_speed [16];
    table_speed = '{`SPEED_L0, `SPEED_L1, `SPEED_L2, `SPEED_L3, `SPEED_L4, `SPEED_L5,
                    `SPEED_L6, `SPEED_L7, `SPEED_L8, `SPEED_L9, `SPEED_L10, `SPEED_L11,
                    `SPEED_L12, `SPEED_L13, `SPEED_L14, `SPEED_L15};
    return table_speed[lvl];
  endfunction

  // Packed BCD digits to a plain decimal number
  function automatic int bcd_to_int(input logic [31:0] bcd);
    int value;
    value = 0;
    for (int i = 7; i >= 0; i--) begin
      value = value * 10 + int'(bcd[4*i +: 4]);
    end
    return value;
  endfunction

  function automatic int clear_points(input int lines, input int lvl, input int strk);
    int pts;
    int bonus;
    pts   = base_points(lines) * (lvl + 1);
    bonus = strk * `STREAK_STEP;
    if (bonus > `STREAK_CAP) bonus = `STREAK_CAP;
    if (lines != 0 && strk > 0) pts = pts + bonus;
    return pts;
  endfunction

  task automatic model_reset();
    model_lines  = 0;
    model_streak = 0;
    model_level  = 0;
    model_score  = 0;
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // ======================================================================
  // Stimulus tasks
  // ======================================================================
  // One clear, then a check 2 cycles after the strobe is sampled
  task automatic apply_clear(input string name, input int lines);
    int pts;
    pts = clear_points(lines, model_level, model_streak);
    @(posedge clk);
    clear_strobe  <= 1'b1;
    lines_cleared <= 3'(lines);
    @(posedge clk);
    clear_strobe  <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    model_score = (model_score + pts) % 100000000;
    model_lines = model_lines + lines;
    if (model_lines > 255) model_lines = 255;
    model_level = model_lines / `LINES_PER_LEVEL;
    if (model_level > `MAX_LEVEL) model_level = `MAX_LEVEL;
    if (lines == 0) model_streak = 0;
    else if (model_streak < 15) model_streak++;
    check_value({name, " score"}, model_score, bcd_to_int(score));
    check_value({name, " level"}, model_level, int'(level));
    check_value({name, " streak"}, model_streak, int'(streak));
  endtask

  task automatic start_new_game(input string name);
    @(posedge clk);
    new_game <= 1'b1;
    @(posedge clk);
    new_game <= 1'b0;
    @(negedge clk);
    model_reset();
    check_value({name, " score"}, 0, bcd_to_int(score));
    check_value({name, " level"}, 0, int'(level));
    check_value({name, " streak"}, 0, int'(streak));
  endtask

  // Count ticks until the first drop request
  task automatic measure_gravity(input string name, input int period);
    int ticks;
    bit seen;
    ticks = 0;
    seen  = 1'b0;
    @(posedge clk);
    piece_active <= 1'b1;
    while (!seen && ticks < 100) begin
      @(posedge clk);
      tick_game <= 1'b1;
      @(posedge clk);
      tick_game <= 1'b0;
      @(negedge clk);
      ticks++;
      seen = drop_request;
    end
    if (!seen) begin
      timeouts++;
      $display("%s: no drop request from the gravity timer within %0d ticks", name, ticks);
    end else begin
      check_value({name, " ticks"}, period, ticks);
    end
    @(posedge clk);
    piece_active <= 1'b0;
  endtask

  task automatic idle_gravity(input string name, input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      tick_game <= 1'b1;
      @(posedge clk);
      tick_game <= 1'b0;
      @(negedge clk);
      check_value({name, " drop_request"}, 0, int'(drop_request));
    end
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================
  initial begin
    seed          = 32'h700cf1c1;
    checks        = 0;
    errors        = 0;
    timeouts      = 0;
    rst           = 1'b1;
    clear_strobe  = 1'b0;
    new_game      = 1'b0;
    tick_game     = 1'b0;
    piece_active  = 1'b0;
    lines_cleared = 3'd0;
    model_reset();

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    measure_gravity("gravity_level0", speed_for_level(0));

    // Base scores from a fresh game
    apply_clear("base_single", 1);
    apply_clear("base_double", 2);
    apply_clear("base_triple", 3);
    apply_clear("base_tetris", 4);

    // Streak grows past the bonus cap, then a zero clear ends it
    apply_clear("streak_5", 1);
    apply_clear("streak_6", 1);
    apply_clear("streak_7", 1);
    apply_clear("streak_break", 0);
    apply_clear("streak_restart", 2);

    for (int i = 0; i < 200; i++) begin
      apply_clear("random_clear", int'($unsigned($random(seed)) % 5));
    end

    measure_gravity("gravity_level_now", speed_for_level(model_level));
    idle_gravity("gravity_inactive", 60);

    start_new_game("new_game");
    apply_clear("new_game_tetris", 4);
    apply_clear("new_game_single", 1);

    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tetris_score_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_consts.svh"

module tetris_score_asserts (
  input logic        clk,
  input logic        rst,
  input logic        clear_strobe,
  input logic        new_game,
  input logic [31:0] score,
  input logic [3:0]  level,
  input logic        drop_request
);

  // ======================================================================
  // Gravity and progression
  // ======================================================================
  // Drop request is a single-cycle pulse
  drop_pulse_a: assert property (@(posedge clk) disable iff (rst)
    drop_request |=> !drop_request)
    else $error("drop_request stayed high for two cycles");

  // Level holds at the top level until a new game, it never wraps past it
  level_cap_a: assert property (@(posedge clk) disable iff (rst)
    ((level == 4'(`MAX_LEVEL)) && !new_game) |=> (level == 4'(`MAX_LEVEL)))
    else $error("level left the top level without a new game");

  // ======================================================================
  // Score
  // ======================================================================
  for (genvar d = 0; d < 8; d++) begin : g_digit
    bcd_digit_a: assert property (@(posedge clk) disable iff (rst)
      score[4*d +: 4] <= 4'd9)
      else $error("score digit %0d holds a non-decimal value", d);
  end

  // Score moves only 2 cycles after a clear strobe or 1 cycle after new game
  score_source_a: assert property (@(posedge clk) disable iff (rst)
    $changed(score) |-> ($past(clear_strobe, 2) || $past(new_game)))
    else $error("score changed without a clear or a new game");

endmodule

bind tetris_score_top tetris_score_asserts u_asserts (
  .clk          (clk),
  .rst          (rst),
  .clear_strobe (clear_strobe),
  .new_game     (new_game),
  .score        (score),
  .level        (level),
  .drop_request (drop_request)
);

`default_nettype wire

//--- hw/tetris_score_top.sv
`timescale 1ns/1ps
`default_nettype none

module tetris_score_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        clear_strobe,
  input  logic        new_game,
  input  logic        tick_game,
  input  logic        piece_active,
  input  logic [2:0]  lines_cleared,
  output logic [31:0] score,
  output logic [3:0]  level,
  output logic [3:0]  streak,
  output logic        drop_request
);
  import tetris_pkg::*;

  frames_t frames;

  score_bus_if bus ();

  // ====================================================================
  // Decode, execute and result stages
  // ====================================================================
  clear_decode u_clear_decode (
    .clk           (clk),
    .rst           (rst),
    .clear_strobe  (clear_strobe),
    .lines_cleared (lines_cleared),
    .bus           (bus.decode_mp)
  );

  bcd_score_adder u_bcd_score_adder (
    .clk      (clk),
    .rst      (rst),
    .new_game (new_game),
    .bus      (bus.execute_mp),
    .score    (score)
  );

  level_tracker u_level_tracker (
    .clk      (clk),
    .rst      (rst),
    .new_game (new_game),
    .bus      (bus.result_mp),
    .frames   (frames)
  );

  gravity_timer u_gravity_timer (
    .clk          (clk),
    .rst          (rst),
    .tick_game    (tick_game),
    .piece_active (piece_active),
    .frames       (frames),
    .drop_request (drop_request)
  );

  assign level  = bus.level;
  assign streak = bus.streak;

endmodule

`default_nettype wire

//--- hw/gravity_timer.sv
`timescale 1ns/1ps
`default_nettype none

module gravity_timer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 tick_game,
  input  logic                 piece_active,
  input  tetris_pkg::frames_t  frames,
  output logic                 drop_request
);
  import tetris_pkg::*;

  frames_t    tick_count;
  logic [6:0] count_next;

  assign count_next = {1'b0, tick_count} + 7'd1;

  // Compare with >= so a sudden level-up with a shorter period
  // still fires instead of counting past the new limit
  always_ff @(posedge clk) begin
    drop_request <= 1'b0;
    if (rst || !piece_active) begin
      tick_count <= '0;
    end else if (tick_game) begin
      if (count_next >= {1'b0, frames}) begin
        tick_count   <= '0;
        drop_request <= 1'b1;
      end else begin
        tick_count <= count_next[5:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/level_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_consts.svh"

module level_tracker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 new_game,
  score_bus_if.result_mp       bus,
  output tetris_pkg::frames_t  frames
);
  import tetris_pkg::*;

  logic [7:0] total_lines;
  logic [8:0] lines_sum;
  logic [7:0] level_raw;

  // ====================================================================
  // Line total and streak
  // ====================================================================
  assign lines_sum = {1'b0, total_lines} + 9'(bus.clear_lines);

  always_ff @(posedge clk) begin
    if (rst || new_game) begin
      total_lines <= '0;
      bus.streak  <= '0;
    end else if (bus.clear_valid) begin
      // Saturate at 255 lines
      total_lines <= lines_sum[8] ? 8'hff : lines_sum[7:0];
      if (bus.clear_lines == '0) begin
        bus.streak <= '0;
      end else if (bus.streak != '1) begin
        bus.streak <= bus.streak + 1'b1;
      end
    end
  end

  // Ten lines per level, capped
  always_comb begin
    level_raw = 8'(total_lines / `LINES_PER_LEVEL);
    if (level_raw > `MAX_LEVEL) begin
      bus.level = level_t'(`MAX_LEVEL);
    end else begin
      bus.level = level_t'(level_raw);
    end
  end

  // ====================================================================
  // Gravity speed curve
  // ====================================================================
  always_comb begin
    case (bus.level)
      4'd0:    frames = frames_t'(`SPEED_L0);
      4'd1:    frames = frames_t'(`SPEED_L1);
      4'd2:    frames = frames_t'(`SPEED_L2);
      4'd3:    frames = frames_t'(`SPEED_L3);
      4'd4:    frames = frames_t'(`SPEED_L4);
      4'd5:    frames = frames_t'(`SPEED_L5);
      4'd6:    frames = frames_t'(`SPEED_L6);
      4'd7:    frames = frames_t'(`SPEED_L7);
      4'd8:    frames = frames_t'(`SPEED_L8);
      4'd9:    frames = frames_t'(`SPEED_L9);
      4'd10:   frames = frames_t'(`SPEED_L10);
      4'd11:   frames = frames_t'(`SPEED_L11);
      4'd12:   frames = frames_t'(`SPEED_L12);
      4'd13:   frames = frames_t'(`SPEED_L13);
      4'd14:   frames = frames_t'(`SPEED_L14);
      default: frames = frames_t'(`SPEED_L15);
    endcase
  end

endmodule

`default_nettype wire

//--- hw/bcd_score_adder.sv
`timescale 1ns/1ps
`default_nettype none

module bcd_score_adder (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    new_game,
  score_bus_if.execute_mp         bus,
  output tetris_pkg::bcd_score_t  score
);
  import tetris_pkg::*;

  points_t    remaining;
  logic [3:0] add_digit;
  logic [4:0] digit_sum;
  logic       carry;
  bcd_score_t next_score;

  // ====================================================================
  // Binary to decimal split and BCD ripple add
  // ====================================================================
  // Each pass peels one decimal digit off the binary points and adds
  // it to the matching score digit. Carry ripples through all eight
  // digits and drops off the top, so the score wraps past 99,999,999.
  always_comb begin
    remaining  = bus.points;
    carry      = 1'b0;
    next_score = score;
    for (int i = 0; i < 8; i++) begin
      add_digit = 4'(remaining % 10);
      remaining = remaining / 10;
      digit_sum = {1'b0, score[4*i +: 4]} + {1'b0, add_digit} + 5'(carry);
      if (digit_sum >= 5'd10) begin
        next_score[4*i +: 4] = 4'(digit_sum - 5'd10);
        carry                = 1'b1;
      end else begin
        next_score[4*i +: 4] = digit_sum[3:0];
        carry                = 1'b0;
      end
    end
  end

  // New game wins over a clear landing in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      score <= '0;
    end else if (new_game) begin
      score <= '0;
    end else if (bus.clear_valid) begin
      score <= next_score;
    end
  end

endmodule

`default_nettype wire

//--- hw/clear_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_consts.svh"

module clear_decode (
  input  logic                clk,
  input  logic                rst,
  input  logic                clear_strobe,
  input  tetris_pkg::lines_t  lines_cleared,
  score_bus_if.decode_mp      bus
);
  import tetris_pkg::*;

  logic [11:0] base_score;
  logic [4:0]  level_mult;
  logic [10:0] bonus_raw;
  logic [9:0]  streak_bonus;
  points_t     scaled;
  points_t     next_points;

  // ====================================================================
  // Points = base * (level + 1) + streak bonus
  // ====================================================================
  always_comb begin
    case (lines_cleared)
      3'd1:    base_score = 12'(`SCORE_SINGLE);
      3'd2:    base_score = 12'(`SCORE_DOUBLE);
      3'd3:    base_score = 12'(`SCORE_TRIPLE);
      3'd4:    base_score = 12'(`SCORE_TETRIS);
      default: base_score = 12'd0;
    endcase

    // Level and streak are still the values from before this clear
    level_mult = 5'(bus.level) + 5'd1;
    scaled     = points_t'(base_score) * points_t'(level_mult);

    bonus_raw = 11'(bus.streak) * 11'(`STREAK_STEP);
    if (lines_cleared == '0 || bus.streak == '0) begin
      streak_bonus = 10'd0;
    end else if (bonus_raw > `STREAK_CAP) begin
      streak_bonus = 10'(`STREAK_CAP);
    end else begin
      streak_bonus = 10'(bonus_raw);
    end

    next_points = scaled + points_t'(streak_bonus);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.clear_valid <= 1'b0;
    end else begin
      bus.clear_valid <= clear_strobe;
    end
  end

  // Line count and points of the registered clear
  always_ff @(posedge clk) begin
    bus.clear_lines <= lines_cleared;
    bus.points      <= next_points;
  end

endmodule

`default_nettype wire

//--- hw/score_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface score_bus_if;
  import tetris_pkg::*;

  // Registered clear result from the decoder
  logic    clear_valid;
  lines_t  clear_lines;
  points_t points;

  // Progression state from the level tracker
  level_t  level;
  streak_t streak;

  modport decode_mp (output clear_valid, clear_lines, points, input level, streak);

  modport execute_mp (input clear_valid, points);

  modport result_mp (input clear_valid, clear_lines, output level, streak);

endinterface

`default_nettype wire

//--- hw/tetris_pkg.sv
`default_nettype none

package tetris_pkg;

  // Lines removed by one lock, 0 to 4
  typedef logic [2:0] lines_t;

  // Level 0 to 15
  typedef logic [3:0] level_t;

  // Consecutive clears, saturates at 15
  typedef logic [3:0] streak_t;

  // Binary points of one clear, worst case 1200 * 16 + 500
  typedef logic [15:0] points_t;

  // Eight BCD digits, ones digit in [3:0]
  typedef logic [31:0] bcd_score_t;

  // Gravity period in game ticks
  typedef logic [5:0] frames_t;

endpackage

`default_nettype wire

//--- hw/tetris_consts.svh
`ifndef TETRIS_CONSTS_SVH
`define TETRIS_CONSTS_SVH

// ======================================================================
// Scoring rules
// ======================================================================

// Base points per clear, before the level multiplier
`define SCORE_SINGLE    40
`define SCORE_DOUBLE    100
`define SCORE_TRIPLE    300
`define SCORE_TETRIS    1200

// Bonus per consecutive clear and its ceiling
`define STREAK_STEP     100
`define STREAK_CAP      500

// ======================================================================
// Progression and gravity
// ======================================================================

`define LINES_PER_LEVEL 10
`define MAX_LEVEL       15

// Drop period per level, in 60 Hz game ticks
`define SPEED_L0        48
`define SPEED_L1        43
`define SPEED_L2        38
`define SPEED_L3        33
`define SPEED_L4        28
`define SPEED_L5        23
`define SPEED_L6        18
`define SPEED_L7        13
`define SPEED_L8        8
`define SPEED_L9        6
`define SPEED_L10       5
`define SPEED_L11       5
`define SPEED_L12       5
`define SPEED_L13       4
`define SPEED_L14       4
`define SPEED_L15       3

`endif
